// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - include
    files:
      - rtl/fetch_types_pkg.sv
      - rtl/mem_bus_pkg.sv
      - rtl/sdp_ram.sv
      - rtl/icache_refill.sv
      - rtl/icache.sv
      - rtl/icache_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_icache_top.sv

// ==== flist.f ====
+incdir+include
rtl/fetch_types_pkg.sv
rtl/mem_bus_pkg.sv
rtl/sdp_ram.sv
rtl/icache_refill.sv
rtl/icache.sv
rtl/icache_top.sv
testbench/tb_mem_model.sv
testbench/tb_icache_top.sv

// ==== include/icache_macros.svh ====
/*
 * Geometry constants for the two-way instruction cache.
 * Included by both type packages and by every RTL file that sizes logic.
 */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// ==================================================
// cache organisation
// ==================================================
`define ICACHE_WAYS 2
`define ICACHE_SETS 16
// 32-bit words per line
`define ICACHE_LINE_WORDS 4

// ==================================================
// address split: tag | index | byte offset
// ==================================================
`define ICACHE_ADDR_W 32
`define ICACHE_OFS_W 4
`define ICACHE_IDX_W 4
// address width minus index and offset
`define ICACHE_TAG_W 24

`endif

// ==== rtl/fetch_types_pkg.sv ====
/*
 * Types of the fetch-side port: requests from the front end and
 * the instruction responses returned by the cache.
 */
`include "icache_macros.svh"

package fetch_types_pkg;

  // ==================================================
  // front end to cache
  // ==================================================
  // handshaken with fetch_req_ready_o
  typedef struct packed {
    logic                      valid;
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetch_req_t;

  // ==================================================
  // cache to front end
  // ==================================================
  // single-cycle pulse, no back-pressure
  typedef struct packed {
    logic                      valid;
    // address that was served
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic [31:0]               instr;
  } fetch_rsp_t;

endpackage

// ==== rtl/icache.sv ====
/*
 * Two-way set-associative instruction cache core. Stage 0 reads tag and
 * data RAMs, stage 1 compares tags and answers hits; a miss stalls, refills
 * the victim way and replays the lookup through the write-first RAMs.
 */
`include "icache_macros.svh"

module icache
  import fetch_types_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         flush_i,
  input  fetch_req_t   fetch_req_i,
  output logic         fetch_req_ready_o,
  output fetch_rsp_t   fetch_rsp_o,
  output mem_rd_req_t  mem_req_o,
  input  logic         mem_req_ready_i,
  input  mem_rd_beat_t mem_beat_i,
  output logic         mem_beat_ready_o
);

  localparam int WAY_W = $clog2(`ICACHE_WAYS);

  typedef logic [`ICACHE_TAG_W-1:0] tag_t;
  typedef logic [`ICACHE_IDX_W-1:0] idx_t;
  typedef logic [WAY_W-1:0]         way_t;

  logic                                      s1_valid_q;
  logic [`ICACHE_ADDR_W-1:0]                 s1_addr_q;
  logic                                      fill_busy_q;
  logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;
  way_t [`ICACHE_SETS-1:0]                   victim_q;

  idx_t                      rd_idx;
  idx_t                      s1_idx;
  tag_t                      s1_tag;
  logic [`ICACHE_OFS_W-3:0]  word_sel;
  tag_t                      tag_rd  [`ICACHE_WAYS];
  line_t                     data_rd [`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0]   way_hit;
  way_t                      hit_way;
  way_t                      fill_way;
  logic                      s1_hit;
  logic                      s1_miss;
  logic                      refill_start;
  logic                      fill_done;
  line_t                     fill_line;

  assign s1_idx   = s1_addr_q[`ICACHE_OFS_W +: `ICACHE_IDX_W];
  assign s1_tag   = s1_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign word_sel = s1_addr_q[`ICACHE_OFS_W-1:2];

  // ==================================================
  // stage 0
  // ==================================================
  assign fetch_req_ready_o = ~(fill_busy_q | s1_miss);
  // while stalled keep reading the stage-1 set, so the fill shows up on replay
  assign rd_idx = fetch_req_ready_o ? fetch_req_i.addr[`ICACHE_OFS_W +: `ICACHE_IDX_W]
                                    : s1_idx;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q  <= 1'b0;
      fill_busy_q <= 1'b0;
    end else begin
      if (fetch_req_ready_o) begin
        s1_valid_q <= fetch_req_i.valid;
      end else if (flush_i) begin
        s1_valid_q <= 1'b0;
      end
      if (refill_start) begin
        fill_busy_q <= 1'b1;
      end else if (fill_done) begin
        fill_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req_ready_o) begin
      s1_addr_q <= fetch_req_i.addr;
    end
  end

  // ==================================================
  // stage 1
  // ==================================================
  always_comb begin
    way_hit = '0;
    hit_way = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_hit[w] = valid_q[w][s1_idx] && (tag_rd[w] == s1_tag);
      if (way_hit[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign s1_hit  = s1_valid_q & (|way_hit);
  assign s1_miss = s1_valid_q & ~(|way_hit);

  always_comb begin
    fetch_rsp_o.valid = s1_hit & ~flush_i;
    fetch_rsp_o.addr  = s1_addr_q;
    fetch_rsp_o.instr = data_rd[hit_way][word_sel];
  end

  // ==================================================
  // miss handling and replacement
  // ==================================================
  assign refill_start = s1_miss & ~fill_busy_q & ~flush_i;
  assign fill_way     = victim_q[s1_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (fill_done) begin
      valid_q[fill_way][s1_idx] <= 1'b1;
      // round robin, next miss in this set takes the other way
      victim_q[s1_idx] <= victim_q[s1_idx] + 1'b1;
    end
  end

  icache_refill u_refill (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (refill_start),
    .line_addr_i      (s1_addr_q),
    .mem_req_o        (mem_req_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_beat_i       (mem_beat_i),
    .mem_beat_ready_o (mem_beat_ready_o),
    .fill_line_o      (fill_line),
    .fill_done_o      (fill_done)
  );

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    logic way_we;

    assign way_we = fill_done & (fill_way == way_t'(w));

    sdp_ram #(.DEPTH(`ICACHE_SETS), .word_t(tag_t)) u_tag_ram (
      .clk     (clk),
      .we_i    (way_we),
      .waddr_i (s1_idx),
      .wdata_i (s1_tag),
      .raddr_i (rd_idx),
      .rdata_o (tag_rd[w])
    );

    sdp_ram #(.DEPTH(`ICACHE_SETS), .word_t(line_t)) u_data_ram (
      .clk     (clk),
      .we_i    (way_we),
      .waddr_i (s1_idx),
      .wdata_i (fill_line),
      .raddr_i (rd_idx),
      .rdata_o (data_rd[w])
    );
  end

  // a line is only ever filled on a miss, so it cannot live in both ways
  a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
    s1_valid_q |-> $onehot0(way_hit));

  a_no_rsp_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
    fill_busy_q |-> !fetch_rsp_o.valid);

endmodule

// ==== rtl/icache_refill.sv ====
/*
 * Miss handler. A start pulse issues one incrementing burst for the line,
 * beats are gathered in a buffer and the full line is presented with the
 * last beat, together with a one-cycle done pulse.
 */
`include "icache_macros.svh"

module icache_refill
  import mem_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start_i,
  input  logic [`ICACHE_ADDR_W-1:0] line_addr_i,
  output mem_rd_req_t               mem_req_o,
  input  logic                      mem_req_ready_i,
  input  mem_rd_beat_t              mem_beat_i,
  output logic                      mem_beat_ready_o,
  output line_t                     fill_line_o,
  output logic                      fill_done_o
);

  localparam int CNT_W = $clog2(`ICACHE_LINE_WORDS);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_BURST
  } state_e;

  state_e                              state_q;
  logic [CNT_W-1:0]                    beat_cnt_q;
  logic [`ICACHE_ADDR_W-1:0]           req_addr_q;
  // all words but the last, which bypasses the buffer
  logic [`ICACHE_LINE_WORDS-2:0][31:0] line_buf_q;
  logic                                beat_fire;

  assign beat_fire = mem_beat_i.valid & mem_beat_ready_o;

  // ==================================================
  // control
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE:  if (start_i) state_q <= ST_REQ;
        ST_REQ:   if (mem_req_ready_i) state_q <= ST_BURST;
        ST_BURST: if (beat_fire && mem_beat_i.last) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
      if (state_q != ST_BURST) begin
        beat_cnt_q <= '0;
      end else if (beat_fire) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // line address and beat payload
  always_ff @(posedge clk) begin
    if (start_i && (state_q == ST_IDLE)) begin
      req_addr_q <= {line_addr_i[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
    end
    if (beat_fire && !mem_beat_i.last) begin
      line_buf_q[beat_cnt_q] <= mem_beat_i.data;
    end
  end

  // ==================================================
  // bus side
  // ==================================================
  always_comb begin
    mem_req_o.valid = (state_q == ST_REQ);
    mem_req_o.addr  = req_addr_q;
    mem_req_o.len   = 8'(`ICACHE_LINE_WORDS - 1);
  end

  assign mem_beat_ready_o = (state_q == ST_BURST);
  assign fill_line_o      = {mem_beat_i.data, line_buf_q};
  assign fill_done_o      = beat_fire & mem_beat_i.last;

  // cache core must not request a second line mid-refill
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (state_q == ST_IDLE));

  // memory must end the burst exactly on the final word
  a_last_at_end: assert property (@(posedge clk) disable iff (!rst_n)
    (beat_fire && mem_beat_i.last) |-> (beat_cnt_q == CNT_W'(`ICACHE_LINE_WORDS - 1)));

endmodule

// ==== rtl/icache_top.sv ====
/*
 * Top level of the instruction cache. Exposes the fetch port and the
 * burst-read memory port of the cache core.
 */
module icache_top
  import fetch_types_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         flush_i,
  input  fetch_req_t   fetch_req_i,
  output logic         fetch_req_ready_o,
  output fetch_rsp_t   fetch_rsp_o,
  output mem_rd_req_t  mem_req_o,
  input  logic         mem_req_ready_i,
  input  mem_rd_beat_t mem_beat_i,
  output logic         mem_beat_ready_o
);

  icache u_icache (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush_i           (flush_i),
    .fetch_req_i       (fetch_req_i),
    .fetch_req_ready_o (fetch_req_ready_o),
    .fetch_rsp_o       (fetch_rsp_o),
    .mem_req_o         (mem_req_o),
    .mem_req_ready_i   (mem_req_ready_i),
    .mem_beat_i        (mem_beat_i),
    .mem_beat_ready_o  (mem_beat_ready_o)
  );

endmodule

// ==== rtl/mem_bus_pkg.sv ====
/*
 * Types of the reduced burst-read memory bus and the cache line
 * assembled from its beats.
 */
`include "icache_macros.svh"

package mem_bus_pkg;

  // ==================================================
  // read address channel
  // ==================================================
  typedef struct packed {
    logic                      valid;
    // always line aligned
    logic [`ICACHE_ADDR_W-1:0] addr;
    // beats minus one
    logic [7:0]                len;
  } mem_rd_req_t;

  // ==================================================
  // read beat channel
  // ==================================================
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
  } mem_rd_beat_t;

  // one full line, word 0 at the lowest address
  typedef logic [`ICACHE_LINE_WORDS-1:0][31:0] line_t;

endpackage

// ==== rtl/sdp_ram.sv ====
/*
 * Simple dual-port synchronous RAM, one write port and one read port.
 * The stored word type is a parameter so tags and lines share this block.
 */
module sdp_ram #(
  parameter int  DEPTH  = 16,
  parameter type word_t = logic [31:0]
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  word_t                    wdata_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output word_t                    rdata_o
);

  word_t mem_q [DEPTH];

  // ==================================================
  // write port
  // ==================================================
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // ==================================================
  // registered read, write-first on collision
  // ==================================================
  always_ff @(posedge clk) begin
    if (we_i && (waddr_i == raddr_i)) begin
      rdata_o <= wdata_i;
    end else begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

// ==== testbench/tb_icache_top.sv ====
/*
 * Testbench for the instruction cache. Runs reset, cold miss, hit,
 * replacement, flush and stalled-memory sequences while assertions check
 * each response against the memory pattern and a reference tag model.
 */
`include "icache_macros.svh"

module tb_icache_top
  import fetch_types_pkg::*;
  import mem_bus_pkg::*;
();

  localparam int          WAIT_LIMIT = 300;
  localparam logic [31:0] PATTERN    = 32'h5a5a_0000;

  logic         clk;
  logic         rst_n;
  logic         flush;
  logic         stall_en;
  fetch_req_t   fetch_req;
  logic         fetch_req_ready;
  fetch_rsp_t   fetch_rsp;
  mem_rd_req_t  mem_req;
  logic         mem_req_ready;
  mem_rd_beat_t mem_beat;
  logic         mem_beat_ready;
  int unsigned  read_count;

  // reference tag model
  logic [`ICACHE_TAG_W-1:0] ref_tag    [`ICACHE_SETS][`ICACHE_WAYS];
  logic                     ref_valid  [`ICACHE_SETS][`ICACHE_WAYS];
  int                       ref_victim [`ICACHE_SETS];
  logic                     expect_hit;
  int unsigned              exp_reads;

  logic        req_fire;
  logic [31:0] rule_instr;
  logic        pend_valid;
  logic [31:0] pend_addr;
  int unsigned fire_count;
  int unsigned rsp_count;
  int          errors;
  int          timeouts;
  logic        timed_out;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  icache_top uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .flush_i           (flush),
    .fetch_req_i       (fetch_req),
    .fetch_req_ready_o (fetch_req_ready),
    .fetch_rsp_o       (fetch_rsp),
    .mem_req_o         (mem_req),
    .mem_req_ready_i   (mem_req_ready),
    .mem_beat_i        (mem_beat),
    .mem_beat_ready_o  (mem_beat_ready)
  );

  tb_mem_model mem (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_en_i       (stall_en),
    .mem_req_i        (mem_req),
    .mem_req_ready_o  (mem_req_ready),
    .mem_beat_o       (mem_beat),
    .mem_beat_ready_i (mem_beat_ready),
    .read_count_o     (read_count)
  );

  // ==================================================
  // outstanding request tracking
  // ==================================================
  assign req_fire   = fetch_req.valid & fetch_req_ready;
  // pattern word for the fetch that is still outstanding
  assign rule_instr = {pend_addr[31:2], 2'b00} ^ PATTERN;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid <= 1'b0;
      pend_addr  <= '0;
      fire_count <= 0;
      rsp_count  <= 0;
    end else begin
      if (req_fire) begin
        pend_valid <= 1'b1;
        pend_addr  <= fetch_req.addr;
        fire_count <= fire_count + 1;
      end else if (fetch_rsp.valid || flush) begin
        pend_valid <= 1'b0;
      end
      if (fetch_rsp.valid) begin
        rsp_count <= rsp_count + 1;
      end
    end
  end

  // ==================================================
  // assertions
  // ==================================================
  a_reset: assert property (@(posedge clk) $rose(rst_n) |->
      (!fetch_rsp.valid && !mem_req.valid && !mem_beat_ready && fetch_req_ready))
    else begin
      errors++;
      $display("error: after reset rsp_valid=%h mem_req_valid=%h beat_ready=%h ready=%h",
               $sampled(fetch_rsp.valid), $sampled(mem_req.valid),
               $sampled(mem_beat_ready), $sampled(fetch_req_ready));
    end

  a_rsp_data: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rsp.valid |-> (fetch_rsp.instr == rule_instr))
    else begin
      errors++;
      $display("error: fetch_rsp_o.instr = %h, expected %h",
               $sampled(fetch_rsp.instr), $sampled(rule_instr));
    end

  a_rsp_addr: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rsp.valid |-> (pend_valid && fetch_rsp.addr == pend_addr))
    else begin
      errors++;
      $display("error: fetch_rsp_o.addr = %h, expected %h, outstanding %h",
               $sampled(fetch_rsp.addr), $sampled(pend_addr), $sampled(pend_valid));
    end

  a_rsp_present: assert property (@(posedge clk) disable iff (!rst_n)
      (pend_valid && fetch_req_ready && !flush) |-> fetch_rsp.valid)
    else begin
      errors++;
      $display("cache went ready again without answering the outstanding fetch");
    end

  a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
      (req_fire && expect_hit) |=>
      (flush || (fetch_rsp.valid && fetch_rsp.addr == $past(fetch_req.addr))))
    else begin
      errors++;
      $display("hit response missing one cycle after the fetch was accepted");
    end

  a_miss_stall: assert property (@(posedge clk) disable iff (!rst_n)
      (req_fire && !expect_hit) |=> (!fetch_rsp.valid && !fetch_req_ready))
    else begin
      errors++;
      $display("cache answered or stayed ready on a fetch that must miss");
    end

  a_burst_form: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req.valid |-> (mem_req.len == 8'(`ICACHE_LINE_WORDS - 1) &&
      mem_req.addr == {pend_addr[31:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}}))
    else begin
      errors++;
      $display("error: mem_req.addr = %h len = %h, expected %h len %h",
               $sampled(mem_req.addr), $sampled(mem_req.len),
               {$sampled(pend_addr[31:`ICACHE_OFS_W]), {`ICACHE_OFS_W{1'b0}}},
               8'(`ICACHE_LINE_WORDS - 1));
    end

  // ==================================================
  // reference model and stimulus helpers
  // ==================================================
  task automatic clear_ref_model();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      ref_victim[s] = 0;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_tag[s][w]   = '0;
      end
    end
  endtask

  // lookup that installs a missing line in the round-robin victim way
  function automatic logic predict_hit(input logic [31:0] addr);
    logic [`ICACHE_IDX_W-1:0] idx;
    logic [`ICACHE_TAG_W-1:0] tag;
    logic                     hit;
    idx = addr[`ICACHE_OFS_W +: `ICACHE_IDX_W];
    tag = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    hit = 1'b0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
        hit = 1'b1;
      end
    end
    if (!hit) begin
      ref_tag[idx][ref_victim[idx]]   = tag;
      ref_valid[idx][ref_victim[idx]] = 1'b1;
      ref_victim[idx] = (ref_victim[idx] + 1) % `ICACHE_WAYS;
    end
    return hit;
  endfunction

  task automatic report_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("timeout: %s", what);
  endtask

  // returns one unit after the edge that accepted the fetch
  task automatic send(input logic [31:0] addr);
    int waited;
    waited     = 0;
    expect_hit = predict_hit(addr);
    if (!expect_hit) begin
      exp_reads++;
    end
    fetch_req.valid = 1'b1;
    fetch_req.addr  = addr;
    @(negedge clk);
    while (!fetch_req_ready && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout("fetch request was never accepted");
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic release_fetch();
    fetch_req.valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while ((pend_valid || !fetch_req_ready) && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout("cache did not return to idle");
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_mem_request();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!mem_req.valid && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_timeout("no burst read was issued for the miss");
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_reads();
    assert (read_count == exp_reads)
      else begin
        errors++;
        $display("error: read_count = %h, expected %h", read_count, exp_reads);
      end
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin : stimulus
    logic [31:0] addr;
    errors     = 0;
    timeouts   = 0;
    timed_out  = 1'b0;
    exp_reads  = 0;
    expect_hit = 1'b0;
    rst_n      = 1'b0;
    flush      = 1'b0;
    stall_en   = 1'b0;
    fetch_req  = '0;
    clear_ref_model();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // cold miss then the rest of the line back to back
    send(32'h0001_2348);
    release_fetch();
    drain();
    check_reads();
    send(32'h0001_2340);
    send(32'h0001_2344);
    send(32'h0001_234c);
    send(32'h0001_2348);
    release_fetch();
    drain();
    check_reads();

    // three tags in set 9 where the third evicts the first fill
    send(32'h0000_1090);
    send(32'h0000_2094);
    send(32'h0000_1098);
    send(32'h0000_209c);
    send(32'h0000_3090);
    send(32'h0000_2090);
    release_fetch();
    drain();
    check_reads();
    send(32'h0000_1094);
    release_fetch();
    drain();
    check_reads();

    // flush during the refill still lands the line
    send(32'h0000_40c4);
    release_fetch();
    wait_mem_request();
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    drain();
    send(32'h0000_40c4);
    release_fetch();
    drain();
    check_reads();

    // mixed fetches against a stalling memory
    stall_en = 1'b1;
    for (int i = 0; i < 24; i++) begin
      addr = {16'h0, 8'h50 + 8'(i / 4 % 3), 4'(2 + i % 2), 2'(i * 3 % 4), 2'b00};
      send(addr);
      if (i % 5 == 4) begin
        release_fetch();
        @(posedge clk);
        #1;
      end
    end
    release_fetch();
    drain();
    stall_en = 1'b0;
    check_reads();

    // exactly one fetch was flushed
    assert (rsp_count == fire_count - 1)
      else begin
        errors++;
        $display("error: rsp_count = %h, expected %h", rsp_count, fire_count - 1);
      end

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_mem_model.sv ====
/*
 * Burst-read memory for the cache testbench. The word at byte address A
 * holds A ^ 32'h5a5a_0000. Random stalls on both channels when enabled.
 */
module tb_mem_model
  import mem_bus_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         stall_en_i,
  input  mem_rd_req_t  mem_req_i,
  output logic         mem_req_ready_o,
  output mem_rd_beat_t mem_beat_o,
  input  logic         mem_beat_ready_i,
  output int unsigned  read_count_o
);

  localparam logic [31:0] PATTERN = 32'h5a5a_0000;

  logic [31:0] lfsr_q;
  logic        req_go_q;
  logic        beat_go_q;
  logic        busy_q;
  logic [31:0] base_q;
  logic [7:0]  len_q;
  logic [7:0]  beat_q;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // ==================================================
  // stall generation, one lfsr bit per channel
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin : stall_gen
    logic [31:0] s1;
    logic [31:0] s2;
    if (!rst_n) begin
      lfsr_q    <= 32'habe0902b;
      req_go_q  <= 1'b0;
      beat_go_q <= 1'b0;
    end else begin
      s1 = lfsr_step(lfsr_q);
      s2 = lfsr_step(s1);
      lfsr_q    <= s2;
      req_go_q  <= !stall_en_i || s1[0];
      beat_go_q <= !stall_en_i || s2[0];
    end
  end

  // ==================================================
  // one burst at a time
  // ==================================================
  assign mem_req_ready_o  = req_go_q && !busy_q;
  assign mem_beat_o.valid = busy_q && beat_go_q;
  assign mem_beat_o.data  = (base_q + 32'({beat_q, 2'b00})) ^ PATTERN;
  assign mem_beat_o.last  = (beat_q == len_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q       <= 1'b0;
      base_q       <= '0;
      len_q        <= '0;
      beat_q       <= '0;
      read_count_o <= 0;
    end else if (mem_req_i.valid && mem_req_ready_o) begin
      busy_q       <= 1'b1;
      base_q       <= mem_req_i.addr;
      len_q        <= mem_req_i.len;
      beat_q       <= '0;
      read_count_o <= read_count_o + 1;
    end else if (mem_beat_o.valid && mem_beat_ready_i) begin
      beat_q <= beat_q + 1'b1;
      if (mem_beat_o.last) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule
